// File: src/spi_reg_params.svh
//--------------------------------------------------------------------
// SPI register slave sizes
// Frame, address and data widths and the register reset content
//--------------------------------------------------------------------
`ifndef SPI_REG_PARAMS_SVH
`define SPI_REG_PARAMS_SVH

// Bits in one frame while cs_n is low
`define SPI_FRAME_BITS 16

// Register address field, bits 13:8 of the frame
`define SPI_ADDR_BITS 6

// Write data field and register width
`define SPI_DATA_BITS 8

// Depth of the register bank, 2**SPI_ADDR_BITS
`define REG_COUNT 64

// Content of every register after reset
`define REG_RESET_VALUE 8'h00

`endif

// File: src/spi_reg_pkg.sv
//--------------------------------------------------------------------
// SPI register slave types
// Packed structs passed between the control and datapath blocks
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

package spi_reg_pkg;

    // Raw SPI pins from the master
    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_s;

    // Single-cycle strobes in the clock domain
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        logic frame_start;
        logic frame_end;
    } spi_strobe_s;

    // Received frame, MSB first on the wire
    typedef struct packed {
        logic                       rd;
        logic                       parity;
        logic [`SPI_ADDR_BITS-1:0]  addr;
        logic [`SPI_DATA_BITS-1:0]  data;
    } spi_cmd_s;

    // Write port of the register bank
    typedef struct packed {
        logic                       wr_en;
        logic [`SPI_ADDR_BITS-1:0]  addr;
        logic [`SPI_DATA_BITS-1:0]  wdata;
    } reg_req_s;

    // Per-frame status pulses
    typedef struct packed {
        logic frame_done;
        logic frame_error;
    } spi_status_s;

endpackage

`default_nettype wire

// File: src/spi_frame_ctrl.sv
//--------------------------------------------------------------------
// SPI frame control
// Pin synchronizers, edge strobes, frame check and write request
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

module spi_frame_ctrl (
    input  logic                        clock,
    input  logic                        reset_n,
    input  spi_reg_pkg::spi_pins_s      pins,
    input  spi_reg_pkg::spi_cmd_s       rx_cmd,
    input  logic                        bit_count_ok,
    output spi_reg_pkg::spi_strobe_s    strobe,
    output logic                        mosi_sync,
    output logic                        cs_n_sync,
    output spi_reg_pkg::reg_req_s       req,
    output logic [`SPI_ADDR_BITS-1:0]   addr_hold,
    output spi_reg_pkg::spi_status_s    status
);

    // Two synchronizer stages for all three pins
    spi_reg_pkg::spi_pins_s     pins_meta;
    spi_reg_pkg::spi_pins_s     pins_sync;
    // Delayed levels for edge detection
    logic                       sclk_prev;
    logic                       cs_n_prev;
    spi_reg_pkg::spi_strobe_s   strobe_next;
    // Frame captured at frame end
    spi_reg_pkg::spi_cmd_s      cmd_q;
    logic                       count_ok_q;
    logic                       eval_pending;
    logic                       frame_valid;
    logic                       wr_en_q;

    // Idle bus is cs_n high, sclk low
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pins_meta <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
            pins_sync <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
            sclk_prev <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            pins_meta <= pins;
            pins_sync <= pins_meta;
            sclk_prev <= pins_sync.sclk;
            cs_n_prev <= pins_sync.cs_n;
        end
    end

    // Bit edges only count inside a frame
    always_comb begin
        strobe_next.sclk_rise   = pins_sync.sclk & ~sclk_prev & ~pins_sync.cs_n;
        strobe_next.sclk_fall   = ~pins_sync.sclk & sclk_prev & ~pins_sync.cs_n;
        strobe_next.frame_start = ~pins_sync.cs_n & cs_n_prev;
        strobe_next.frame_end   = pins_sync.cs_n & ~cs_n_prev;
    end

    // Edge register, strobes land 3 cycles after the pin change
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            strobe <= '0;
        end else begin
            strobe <= strobe_next;
        end
    end

    assign mosi_sync = pins_sync.mosi;
    // cs_n level that changes in the same cycle as the frame strobes
    assign cs_n_sync = cs_n_prev;

    // Received word held for the check and the write
    always_ff @(posedge clock) begin
        if (strobe.frame_end) begin
            cmd_q <= rx_cmd;
        end
    end

    // Address is kept for the response of the next frame
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            addr_hold    <= '0;
            count_ok_q   <= 1'b0;
            eval_pending <= 1'b0;
        end else begin
            eval_pending <= strobe.frame_end;
            if (strobe.frame_end) begin
                addr_hold  <= rx_cmd.addr;
                count_ok_q <= bit_count_ok;
            end
        end
    end

    // 16 bits, even parity over the word, and not an idle all-ones line
    assign frame_valid = count_ok_q & ~(^cmd_q) & (cmd_q != '1);

    // Write request and status go out together
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_q <= 1'b0;
            status  <= '0;
        end else begin
            wr_en_q            <= eval_pending & frame_valid & ~cmd_q.rd;
            status.frame_done  <= eval_pending;
            status.frame_error <= eval_pending & ~frame_valid;
        end
    end

    always_comb begin
        req.wr_en = wr_en_q;
        req.addr  = cmd_q.addr;
        req.wdata = cmd_q.data;
    end

endmodule

`default_nettype wire

// File: src/spi_shift_in.sv
//--------------------------------------------------------------------
// SPI receive shifter
// Collects MOSI bits MSB first and counts them per frame
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

module spi_shift_in (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        mosi_sync,
    input  spi_reg_pkg::spi_strobe_s    strobe,
    output spi_reg_pkg::spi_cmd_s       rx_cmd,
    output logic                        bit_count_ok
);

    // Counter reaches one past a full frame and stays there
    localparam int COUNT_BITS = $clog2(`SPI_FRAME_BITS + 2);
    localparam logic [COUNT_BITS-1:0] COUNT_FULL = COUNT_BITS'(`SPI_FRAME_BITS);
    localparam logic [COUNT_BITS-1:0] COUNT_OVER = COUNT_FULL + 1'b1;

    logic [`SPI_FRAME_BITS-1:0] shift_q;
    logic [COUNT_BITS-1:0]      count_q;

    // New bit enters at the bottom, first bit ends at the top
    always_ff @(posedge clock) begin
        if (strobe.frame_start) begin
            shift_q <= '0;
        end else if (strobe.sclk_rise) begin
            shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], mosi_sync};
        end
    end

    // Saturating so long frames never wrap back to 16
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (strobe.frame_start) begin
            count_q <= '0;
        end else if (strobe.sclk_rise && count_q != COUNT_OVER) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign rx_cmd       = spi_reg_pkg::spi_cmd_s'(shift_q);
    assign bit_count_ok = (count_q == COUNT_FULL);

endmodule

`default_nettype wire

// File: src/spi_shift_out.sv
//--------------------------------------------------------------------
// SPI transmit shifter
// Builds the response word and shifts it onto MISO
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

module spi_shift_out (
    input  logic                        clock,
    input  logic                        reset_n,
    input  spi_reg_pkg::spi_strobe_s    strobe,
    input  logic                        cs_n_sync,
    input  logic [`SPI_ADDR_BITS-1:0]   addr_hold,
    input  logic [`SPI_DATA_BITS-1:0]   rd_data,
    output logic                        miso
);

    // Zero bits above the parity bit
    localparam int PAD_BITS = `SPI_FRAME_BITS - `SPI_DATA_BITS - 1;

    logic                       tx_parity;
    logic [`SPI_FRAME_BITS-1:0] resp_word;
    logic [`SPI_FRAME_BITS-1:0] shift_q;

    // Parity covers a leading 1, the latched address and the data
    assign tx_parity = ^{1'b1, addr_hold, rd_data};

    // Response layout is zeros, parity, then register data
    assign resp_word = {{PAD_BITS{1'b0}}, tx_parity, rd_data};

    // Top bit is on the line from frame start
    // Each falling sclk moves the next bit up
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
        end else if (strobe.frame_start) begin
            shift_q <= resp_word;
        end else if (strobe.sclk_fall) begin
            shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], 1'b0};
        end
    end

    // Line idles high outside a frame
    assign miso = cs_n_sync | shift_q[`SPI_FRAME_BITS-1];

endmodule

`default_nettype wire

// File: src/reg_bank.sv
//--------------------------------------------------------------------
// Register bank
// 64 by 8 storage, one synchronous write port, one async read port
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

module reg_bank (
    input  logic                        clock,
    input  logic                        reset_n,
    input  spi_reg_pkg::reg_req_s       req,
    input  logic [`SPI_ADDR_BITS-1:0]   rd_addr,
    output logic [`SPI_DATA_BITS-1:0]   rd_data
);

    // One entry per address
    logic [`SPI_DATA_BITS-1:0] regs [`REG_COUNT];

    // All entries come out of reset with a known value
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= `REG_RESET_VALUE;
            end
        end else if (req.wr_en) begin
            regs[req.addr] <= req.wdata;
        end
    end

    // Read follows the address with no clock
    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// File: src/spi_reg_top.sv
//--------------------------------------------------------------------
// SPI register slave top
// Joins frame control, the shifters and the register bank
//--------------------------------------------------------------------
`default_nettype none

`include "spi_reg_params.svh"

module spi_reg_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  spi_reg_pkg::spi_pins_s      pins,
    output logic                        miso,
    output spi_reg_pkg::spi_status_s    status
);

    // Control to datapath
    spi_reg_pkg::spi_strobe_s   strobe;
    logic                       mosi_sync;
    logic                       cs_n_sync;
    // Receive path back to control
    spi_reg_pkg::spi_cmd_s      rx_cmd;
    logic                       bit_count_ok;
    // Bank access
    spi_reg_pkg::reg_req_s      req;
    logic [`SPI_ADDR_BITS-1:0]  addr_hold;
    logic [`SPI_DATA_BITS-1:0]  rd_data;

    spi_frame_ctrl ctrl_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .pins         (pins),
        .rx_cmd       (rx_cmd),
        .bit_count_ok (bit_count_ok),
        .strobe       (strobe),
        .mosi_sync    (mosi_sync),
        .cs_n_sync    (cs_n_sync),
        .req          (req),
        .addr_hold    (addr_hold),
        .status       (status)
    );

    spi_shift_in shift_in_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .mosi_sync    (mosi_sync),
        .strobe       (strobe),
        .rx_cmd       (rx_cmd),
        .bit_count_ok (bit_count_ok)
    );

    // Response uses the address of the previous frame
    spi_shift_out shift_out_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .strobe    (strobe),
        .cs_n_sync (cs_n_sync),
        .addr_hold (addr_hold),
        .rd_data   (rd_data),
        .miso      (miso)
    );

    reg_bank bank_i (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req),
        .rd_addr (addr_hold),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: testbench/spi_reg_properties.sv
//--------------------------------------------------------------------
// SPI register slave checks
// Pin idle level and status pulse rules, bound into the top level
//--------------------------------------------------------------------
`default_nettype none

module spi_reg_properties (
    input logic                         clock,
    input logic                         reset_n,
    input logic                         miso,
    input spi_reg_pkg::spi_pins_s       pins,
    input spi_reg_pkg::reg_req_s        req,
    input spi_reg_pkg::spi_status_s     status
);

    timeunit 1ns;
    timeprecision 1ps;

    // Line idles high between frames
    // cs_n pin level after the two sync stages and the edge register
    miso_idle_high: assert property (@(posedge clock) disable iff (!reset_n)
        $past(pins.cs_n, 3) |-> miso)
        else $error("miso low while the synchronized cs_n is high");

    // Status strobes last one clock
    done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        status.frame_done |=> !status.frame_done)
        else $error("frame_done held longer than one cycle");

    error_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        status.frame_error |=> !status.frame_error)
        else $error("frame_error held longer than one cycle");

    // A rejected frame never reaches the bank
    no_write_on_error: assert property (@(posedge clock) disable iff (!reset_n)
        !(status.frame_error && req.wr_en))
        else $error("write request during a frame error");

    write_with_done: assert property (@(posedge clock) disable iff (!reset_n)
        req.wr_en |-> status.frame_done)
        else $error("write request without frame_done");

endmodule

bind spi_reg_top spi_reg_properties props_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .miso      (miso),
    .pins      (pins),
    .req       (req),
    .status    (status)
);

`default_nettype wire

// File: testbench/spi_reg_tb.sv
//--------------------------------------------------------------------
// SPI register slave testbench
// Acts as SPI master from a data file, checks MISO and frame status
//--------------------------------------------------------------------
`default_nettype none

module spi_reg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string DATA_FILE = "testbench/spi_reg_testdata.txt";
    // frame_done is due 5 clocks after cs_n rises
    localparam int DONE_TIMEOUT = 40;

    logic                       clock;
    logic                       reset_n;
    spi_reg_pkg::spi_pins_s     pins;
    logic                       miso;
    spi_reg_pkg::spi_status_s   status;
    int                         errors;
    int                         checks;

    spi_reg_top dut_i (
        .clock   (clock),
        .reset_n (reset_n),
        .pins    (pins),
        .miso    (miso),
        .status  (status)
    );

    always #20 clock = ~clock;

    // Command word with even parity over all 16 bits
    function automatic logic [15:0] build_word(input logic rd, input logic [5:0] addr,
                                               input logic [7:0] data);
        return {rd, ^{rd, addr, data}, addr, data};
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
            errors++;
        end
    endtask

    // Mode 0 master, sclk 4 clocks low then 4 high
    // MISO is taken at the falling clock after each sclk rise
    task automatic run_frame(input logic [15:0] word, input int nbits, output logic [15:0] rx,
                             output logic err, output logic done);
        int wait_cnt;
        rx = '0;
        err = 1'b0;
        done = 1'b0;
        wait_cnt = 0;
        @(posedge clock);
        pins.cs_n <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            pins.sclk <= 1'b0;
            pins.mosi <= word[15 - i];
            repeat (4) @(posedge clock);
            pins.sclk <= 1'b1;
            @(negedge clock);
            rx = {rx[14:0], miso};
            repeat (4) @(posedge clock);
        end
        pins.sclk <= 1'b0;
        repeat (4) @(posedge clock);
        pins.cs_n <= 1'b1;
        pins.mosi <= 1'b0;
        while (!done && wait_cnt < DONE_TIMEOUT) begin
            @(negedge clock);
            if (status.frame_done) begin
                done = 1'b1;
                err = status.frame_error;
            end
            wait_cnt++;
        end
    endtask

    initial begin
        int fd;
        int c;
        int code;
        int nbits;
        int frame_no;
        logic [8*128-1:0] rest;
        logic [5:0] addr;
        logic [5:0] prev_addr;
        logic [7:0] data;
        logic [15:0] exp_miso;
        logic exp_err;
        logic [15:0] word;
        logic [15:0] rx;
        logic [15:0] latched;
        logic [15:0] rule_word;
        logic err;
        logic done;
        string name;
        clock = 1'b0;
        reset_n = 1'b0;
        pins = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
        errors = 0;
        checks = 0;
        frame_no = 0;
        // Bank answers for address 0 until the first frame ends
        prev_addr = '0;
        void'($urandom(32'hb224));
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        repeat (4) @(posedge clock);
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", DATA_FILE);
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    code = $fgets(rest, fd);
                end else if (c == "W" || c == "R" || c == "P" || c == "S" || c == "I") begin
                    code = $fscanf(fd, " %h %h %h %h", addr, data, exp_miso, exp_err);
                    frame_no++;
                    if (code != 4) begin
                        $display("Malformed line for frame %0d in %s", frame_no, DATA_FILE);
                        errors++;
                    end
                    name = $sformatf("frame %0d (%c)", frame_no, c);
                    word = build_word(c == "R", addr, data);
                    nbits = (c == "S") ? 12 : 16;
                    if (c == "P") begin
                        word[14] = ~word[14];
                    end
                    if (c == "I") begin
                        word = 16'hffff;
                    end
                    run_frame(word, nbits, rx, err, done);
                    // A short frame only returns the top bits of the response
                    check_value({name, " miso"}, exp_miso >> (16 - nbits), rx);
                    if (!done) begin
                        $display("Timeout: no frame_done after %s", name);
                        errors++;
                    end else begin
                        check_value({name, " error flag"}, 16'(exp_err), 16'(err));
                    end
                    // Zeros on top, parity of 1, last address and data at bit 8
                    rule_word = {7'b0, ^{1'b1, prev_addr, exp_miso[7:0]}, exp_miso[7:0]};
                    check_value({name, " response rule"}, rule_word >> (16 - nbits), rx);
                    // Address bits as they sit in the receive shifter
                    latched = word >> (16 - nbits);
                    prev_addr = latched[13:8];
                    repeat (8 + ($urandom % 13)) @(posedge clock);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        $display("Frames: %0d, checks: %0d, errors: %0d", frame_no, checks, errors);
        if (errors == 0 && frame_no > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/spi_reg_testdata.txt
# kind addr data miso err, all hex, miso is the full response word of that frame
# kinds W write, R read, P bad parity write, S 12-bit write, I all ones
R 05 00 0100 0
W 05 A5 0100 0
R 05 00 01A5 0
W 12 3C 01A5 0
W 2B 81 013C 0
W 3E 7F 0181 0
R 12 00 017F 0
R 3E 00 013C 0
R 2B 00 017F 0
R 05 00 0181 0
P 12 FF 01A5 1
R 12 00 013C 0
W 01 5A 013C 0
R 01 00 005A 0
S 3E 00 005A 1
R 3E 00 0000 0
I 3F FF 017F 1
R 3F 00 0100 0
R 2B 00 0100 0
R 00 00 0181 0

// File: flist.f
+incdir+src
src/spi_reg_pkg.sv
src/spi_frame_ctrl.sv
src/spi_shift_in.sv
src/spi_shift_out.sv
src/reg_bank.sv
src/spi_reg_top.sv
testbench/spi_reg_properties.sv
testbench/spi_reg_tb.sv
